//--- logic/cpu_macros.svh
// Width macros for the pipeline hazard controller
// Register address, opcode, memory operation and data word sizes
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// General purpose register file has 32 entries
`define REG_ADDR_W 5 // r0..r31

// Primary opcode field of the instruction word
`define OP_W 6

// Memory operation code carried down the pipe
// Top bit set marks a load, top two bits 01 mark a store
`define MEM_OP_W 4

// Datapath word, registers and memory data
`define WORD_W 32

`endif

//--- logic/cpu_pkg.sv
// Shared types for the hazard controller
// Register, opcode, mem-op and bypass select types, class helpers
`include "cpu_macros.svh"

package cpu_pkg;

    // Register number, one of 32 GPRs of `WORD_W bits each
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`OP_W-1:0]       opcode_t;   // Primary opcode
    typedef logic [`MEM_OP_W-1:0]   mem_op_t;   // Memory operation

    // Bypass source for an ID operand
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00, // Value from register file
        FWD_EX   = 2'b01, // Result of instruction in EX
        FWD_MEM  = 2'b10  // Result of instruction in MEM
    } fwd_ctrl_e;

    localparam opcode_t OP_ST = 6'h2b; // Word store

    // Mem-op class tags in the upper bits
    localparam logic       MEM_CLASS_LOAD  = 1'b1;  // 1xxx
    localparam logic [1:0] MEM_CLASS_STORE = 2'b01; // 01xx

    // Load when the top bit is set
    function automatic logic is_load(input mem_op_t mop);
        return mop[`MEM_OP_W-1] == MEM_CLASS_LOAD;
    endfunction

    // Store when the top two bits read 01
    function automatic logic is_store(input mem_op_t mop);
        return mop[`MEM_OP_W-1 -: 2] == MEM_CLASS_STORE;
    endfunction

endpackage

//--- logic/pipe_track.sv
// Controller copy of the ID/EX and EX/MEM pipeline registers
// Only the fields needed for hazard and bypass decisions
`timescale 1ns/1ps

module pipe_track (
    input  logic               clk,
    input  logic               reset,
    input  logic               advance,    // Pipe moves this edge
    input  logic               bubble,     // Insert empty slot into EX
    input  logic               id_valid,
    input  cpu_pkg::reg_addr_t dst_addr,   // ID destination
    input  cpu_pkg::reg_addr_t ra_addr,
    input  cpu_pkg::reg_addr_t rb_addr,
    input  logic               gpr_we,
    input  cpu_pkg::mem_op_t   mem_op,
    output logic               ex_valid,
    output logic               ex_gpr_we,
    output cpu_pkg::reg_addr_t ex_dst,
    output cpu_pkg::reg_addr_t ex_ra_addr, // Kept for store data bypass
    output cpu_pkg::reg_addr_t ex_rb_addr,
    output cpu_pkg::mem_op_t   ex_mem_op,
    output logic               mem_valid,
    output logic               mem_gpr_we,
    output cpu_pkg::reg_addr_t mem_dst,
    output cpu_pkg::mem_op_t   mem_mem_op
);

    // Valid bits, the only control state here
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
        end else if (advance) begin
            ex_valid  <= id_valid & ~bubble; // Flushed slot enters empty
            mem_valid <= ex_valid;
        end
    end

    // ID to EX fields, frozen while stalled
    always_ff @(posedge clk) begin
        if (advance) begin
            ex_gpr_we  <= gpr_we;
            ex_dst     <= dst_addr;
            ex_ra_addr <= ra_addr;
            ex_rb_addr <= rb_addr;
            ex_mem_op  <= mem_op;
        end
    end

    // EX to MEM fields
    always_ff @(posedge clk) begin
        if (advance) begin
            mem_gpr_we <= ex_gpr_we;
            mem_dst    <= ex_dst;
            mem_mem_op <= ex_mem_op;
        end
    end

endmodule

//--- logic/fwd_select.sv
// Bypass source selection for ID operands and store data in EX
// EX result wins over MEM result, r0 is never bypassed
`timescale 1ns/1ps

module fwd_select (
    input  logic [1:0]          src_reg_used, // Bit 0 ra, bit 1 rb
    input  cpu_pkg::reg_addr_t  ra_addr,
    input  cpu_pkg::reg_addr_t  rb_addr,
    input  logic                ex_valid,
    input  logic                ex_gpr_we,
    input  cpu_pkg::reg_addr_t  ex_dst,
    input  cpu_pkg::reg_addr_t  ex_ra_addr,
    input  cpu_pkg::reg_addr_t  ex_rb_addr,
    input  cpu_pkg::mem_op_t    ex_mem_op,
    input  logic                mem_valid,
    input  logic                mem_gpr_we,
    input  cpu_pkg::reg_addr_t  mem_dst,
    input  cpu_pkg::mem_op_t    mem_mem_op,
    output cpu_pkg::fwd_ctrl_e  ra_fwd_raw,   // Before load-use gating
    output cpu_pkg::fwd_ctrl_e  rb_fwd_raw,
    output logic                ex_ra_fwd_en, // Store data from MEM load
    output logic                ex_rb_fwd_en
);

    logic ex_wr;    // EX will write a GPR
    logic mem_wr;   // MEM will write a GPR
    logic mem_load; // Loaded data sits in MEM
    logic ex_store; // Store waiting for its data in EX

    // Priority pick for one operand
    function automatic cpu_pkg::fwd_ctrl_e pick_src(
        input logic               used,
        input cpu_pkg::reg_addr_t src,
        input logic               wr_e,
        input cpu_pkg::reg_addr_t dst_e,
        input logic               wr_m,
        input cpu_pkg::reg_addr_t dst_m
    );
        logic live;
        live = used && (src != '0); // r0 reads as zero
        if (live && wr_e && (src == dst_e)) begin
            return cpu_pkg::FWD_EX;
        end else if (live && wr_m && (src == dst_m)) begin
            return cpu_pkg::FWD_MEM;
        end
        return cpu_pkg::FWD_NONE;
    endfunction

    assign ex_wr  = ex_valid & ex_gpr_we;
    assign mem_wr = mem_valid & mem_gpr_we;

    assign ra_fwd_raw = pick_src(src_reg_used[0], ra_addr, ex_wr, ex_dst, mem_wr, mem_dst);
    assign rb_fwd_raw = pick_src(src_reg_used[1], rb_addr, ex_wr, ex_dst, mem_wr, mem_dst);

    assign mem_load = mem_wr & cpu_pkg::is_load(mem_mem_op);
    assign ex_store = cpu_pkg::is_store(ex_mem_op);

    // Load in MEM feeding the store in EX
    assign ex_ra_fwd_en = mem_load && ex_store &&
                          (ex_ra_addr != '0) && (ex_ra_addr == mem_dst);
    assign ex_rb_fwd_en = mem_load && ex_store &&
                          (ex_rb_addr != '0) && (ex_rb_addr == mem_dst);

endmodule

//--- logic/load_hazard.sv
// Load-use detection between ID and a load in EX
`timescale 1ns/1ps

module load_hazard (
    input  logic                id_valid,
    input  cpu_pkg::opcode_t    op,           // ID opcode
    input  cpu_pkg::reg_addr_t  ra_addr,
    input  cpu_pkg::reg_addr_t  rb_addr,
    input  logic [1:0]          src_reg_used,
    input  logic                ex_valid,
    input  logic                ex_gpr_we,
    input  cpu_pkg::reg_addr_t  ex_dst,
    input  cpu_pkg::mem_op_t    ex_mem_op,
    output logic                ld_hazard     // Hold ID one cycle
);

    logic ex_load; // Real load to a nonzero register in EX
    logic is_st;   // ID instruction is a store
    logic ra_hit;
    logic rb_hit;

    assign ex_load = ex_valid && ex_gpr_we && cpu_pkg::is_load(ex_mem_op) &&
                     (ex_dst != '0);
    assign is_st   = (op == cpu_pkg::OP_ST);

    assign ra_hit = src_reg_used[0] && (ra_addr == ex_dst);

    // Store data operand gets the load value in EX, no stall needed
    assign rb_hit = src_reg_used[1] && (rb_addr == ex_dst) && !is_st;

    assign ld_hazard = id_valid && ex_load && (ra_hit || rb_hit);

endmodule

//--- logic/stall_ctrl.sv
// Per-stage stall and flush strobes, tracker advance and bubble
// Bypass selects are dropped for an instruction held by load-use
`timescale 1ns/1ps

module stall_ctrl (
    input  logic                if_busy,     // Fetch miss
    input  logic                mem_busy,    // Data miss
    input  logic                br_taken,
    input  logic                ld_hazard,
    input  logic                id_valid,
    input  cpu_pkg::fwd_ctrl_e  ra_fwd_raw,
    input  cpu_pkg::fwd_ctrl_e  rb_fwd_raw,
    output logic                if_stall,
    output logic                id_stall,
    output logic                ex_stall,
    output logic                mem_stall,
    output logic                id_flush,
    output logic                advance,     // Tracker shifts
    output logic                bubble,      // Empty slot into EX
    output cpu_pkg::fwd_ctrl_e  ra_fwd_ctrl,
    output cpu_pkg::fwd_ctrl_e  rb_fwd_ctrl
);

    logic stall; // Any cache miss freezes the whole pipe

    assign stall = if_busy | mem_busy;

    assign if_stall  = stall | ld_hazard; // Refetch nothing while ID waits
    assign id_stall  = stall;
    assign ex_stall  = stall;
    assign mem_stall = stall;

    // Kill ID on a taken branch or a held load consumer
    assign id_flush = ld_hazard | br_taken;

    assign advance = ~stall;
    assign bubble  = id_flush | ~id_valid;

    // Held instruction is not issued this cycle
    assign ra_fwd_ctrl = ld_hazard ? cpu_pkg::FWD_NONE : ra_fwd_raw;
    assign rb_fwd_ctrl = ld_hazard ? cpu_pkg::FWD_NONE : rb_fwd_raw;

endmodule

//--- logic/hazard_unit.sv
// Hazard and forwarding controller for the five-stage pipe
// Tracker, bypass select, load-use check and stall combiner
`timescale 1ns/1ps

module hazard_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                if_busy,
    input  logic                mem_busy,
    input  logic                br_taken,
    input  logic                id_valid,     // ID record present
    input  cpu_pkg::opcode_t    op,
    input  cpu_pkg::reg_addr_t  ra_addr,
    input  cpu_pkg::reg_addr_t  rb_addr,
    input  logic [1:0]          src_reg_used,
    input  cpu_pkg::reg_addr_t  dst_addr,
    input  logic                gpr_we,       // Active high
    input  cpu_pkg::mem_op_t    mem_op,
    output logic                if_stall,
    output logic                id_stall,
    output logic                ex_stall,
    output logic                mem_stall,
    output logic                id_flush,
    output cpu_pkg::fwd_ctrl_e  ra_fwd_ctrl,
    output cpu_pkg::fwd_ctrl_e  rb_fwd_ctrl,
    output logic                ex_ra_fwd_en,
    output logic                ex_rb_fwd_en
);

    // Tracked EX record
    logic               ex_valid;
    logic               ex_gpr_we;
    cpu_pkg::reg_addr_t ex_dst;
    cpu_pkg::reg_addr_t ex_ra_addr;
    cpu_pkg::reg_addr_t ex_rb_addr;
    cpu_pkg::mem_op_t   ex_mem_op;

    // Tracked MEM record
    logic               mem_valid;
    logic               mem_gpr_we;
    cpu_pkg::reg_addr_t mem_dst;
    cpu_pkg::mem_op_t   mem_mem_op;

    logic               advance;
    logic               bubble;
    logic               ld_hazard;
    cpu_pkg::fwd_ctrl_e ra_fwd_raw;   // Ungated selects
    cpu_pkg::fwd_ctrl_e rb_fwd_raw;

    pipe_track i_track (
        .clk(clk), .reset(reset), .advance(advance), .bubble(bubble),
        .id_valid(id_valid), .dst_addr(dst_addr), .ra_addr(ra_addr),
        .rb_addr(rb_addr), .gpr_we(gpr_we), .mem_op(mem_op),
        .ex_valid(ex_valid), .ex_gpr_we(ex_gpr_we), .ex_dst(ex_dst),
        .ex_ra_addr(ex_ra_addr), .ex_rb_addr(ex_rb_addr), .ex_mem_op(ex_mem_op),
        .mem_valid(mem_valid), .mem_gpr_we(mem_gpr_we), .mem_dst(mem_dst),
        .mem_mem_op(mem_mem_op)
    );

    fwd_select i_fwd (
        .src_reg_used(src_reg_used), .ra_addr(ra_addr), .rb_addr(rb_addr),
        .ex_valid(ex_valid), .ex_gpr_we(ex_gpr_we), .ex_dst(ex_dst),
        .ex_ra_addr(ex_ra_addr), .ex_rb_addr(ex_rb_addr), .ex_mem_op(ex_mem_op),
        .mem_valid(mem_valid), .mem_gpr_we(mem_gpr_we), .mem_dst(mem_dst),
        .mem_mem_op(mem_mem_op), .ra_fwd_raw(ra_fwd_raw), .rb_fwd_raw(rb_fwd_raw),
        .ex_ra_fwd_en(ex_ra_fwd_en), .ex_rb_fwd_en(ex_rb_fwd_en)
    );

    load_hazard i_ld_hz (
        .id_valid(id_valid), .op(op), .ra_addr(ra_addr), .rb_addr(rb_addr),
        .src_reg_used(src_reg_used), .ex_valid(ex_valid), .ex_gpr_we(ex_gpr_we),
        .ex_dst(ex_dst), .ex_mem_op(ex_mem_op), .ld_hazard(ld_hazard)
    );

    stall_ctrl i_stall (
        .if_busy(if_busy), .mem_busy(mem_busy), .br_taken(br_taken),
        .ld_hazard(ld_hazard), .id_valid(id_valid),
        .ra_fwd_raw(ra_fwd_raw), .rb_fwd_raw(rb_fwd_raw),
        .if_stall(if_stall), .id_stall(id_stall), .ex_stall(ex_stall),
        .mem_stall(mem_stall), .id_flush(id_flush), .advance(advance),
        .bubble(bubble), .ra_fwd_ctrl(ra_fwd_ctrl), .rb_fwd_ctrl(rb_fwd_ctrl)
    );

endmodule

//--- tb/hazard_unit_assertions.sv
// Concurrent checks on the stall and flush strobes of hazard_unit
// Attached to every hazard_unit instance by bind
`timescale 1ns/1ps

module hazard_unit_assertions (
    input logic clk,
    input logic reset,
    input logic if_busy,
    input logic mem_busy,
    input logic ld_hazard,
    input logic if_stall,
    input logic id_stall,
    input logic ex_stall,
    input logic mem_stall,
    input logic ex_valid,
    input logic mem_valid
);

    int unsigned fail_count = 0; // Read by the testbench at the end

    // Fetch must hold on any miss or load-use stall
    a_if_stall: assert property (@(posedge clk) disable iff (reset)
        (ld_hazard || if_busy || mem_busy) |-> if_stall)
        else begin
            $error("if_stall low while a stall cause is active");
            fail_count++;
        end

    // Tracker empty right after a reset edge
    a_reset_clear: assert property (@(posedge clk)
        reset |=> (!ex_valid && !mem_valid))
        else begin
            $error("tracker valid bits set after reset");
            fail_count++;
        end

    // Back end stages freeze together
    a_stall_equal: assert property (@(posedge clk) disable iff (reset)
        (id_stall == ex_stall) && (ex_stall == mem_stall))
        else begin
            $error("id, ex and mem stall strobes disagree");
            fail_count++;
        end

endmodule

bind hazard_unit hazard_unit_assertions i_assert (
    .clk(clk), .reset(reset), .if_busy(if_busy), .mem_busy(mem_busy),
    .ld_hazard(ld_hazard), .if_stall(if_stall), .id_stall(id_stall),
    .ex_stall(ex_stall), .mem_stall(mem_stall), .ex_valid(ex_valid),
    .mem_valid(mem_valid)
);

//--- tb/tb_hazard_unit.sv
// Testbench for hazard_unit with directed and LFSR random tests
// Reference model of the EX/MEM records, per-cycle compare, watchdog
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_hazard_unit;

    localparam int PERIOD_NS = 100;
    localparam int RESET_CYC = 2;
    localparam int TEST_CYC  = 4 + 14 + 10 + 10 + 14 + 304; // Sum of per-test upper bounds
    localparam int WATCHDOG_CYC = RESET_CYC + TEST_CYC + 20;

    localparam cpu_pkg::opcode_t OP_ALU = 6'h00;
    localparam cpu_pkg::opcode_t OP_LD  = 6'h23;
    localparam cpu_pkg::mem_op_t MOP_NONE = 4'b0000;
    localparam cpu_pkg::mem_op_t MOP_LW   = 4'b1000; // Load class
    localparam cpu_pkg::mem_op_t MOP_SW   = 4'b0100; // Store class

    typedef struct packed {
        logic               ld_hz;
        logic               if_stall;
        logic               stall;
        logic               id_flush;
        logic               advance;
        logic               bubble;
        cpu_pkg::fwd_ctrl_e ra;
        cpu_pkg::fwd_ctrl_e rb;
        logic               st_a;
        logic               st_b;
    } exp_t;

    logic clk, reset, if_busy, mem_busy, br_taken, id_valid, gpr_we;
    cpu_pkg::opcode_t   op;
    cpu_pkg::reg_addr_t ra_addr, rb_addr, dst_addr;
    logic [1:0]         src_reg_used;
    cpu_pkg::mem_op_t   mem_op;
    logic if_stall, id_stall, ex_stall, mem_stall, id_flush, ex_ra_fwd_en, ex_rb_fwd_en;
    cpu_pkg::fwd_ctrl_e ra_fwd_ctrl, rb_fwd_ctrl;

    // Model copy of the tracked records
    logic mdl_ex_valid = 1'b0, mdl_ex_we = 1'b0, mdl_mem_valid = 1'b0, mdl_mem_we = 1'b0;
    cpu_pkg::reg_addr_t mdl_ex_dst = '0, mdl_ex_ra = '0, mdl_ex_rb = '0, mdl_mem_dst = '0;
    cpu_pkg::mem_op_t   mdl_ex_mop = '0, mdl_mem_mop = '0;

    logic        exp_if_stall = 1'b0; // Steers the ID hold on the next edge
    logic [31:0] lfsr = 32'h5e355d44;
    string       cur_test = "reset";
    int unsigned checks = 0, errors = 0, test_start_errors = 0, tests_done = 0;

    hazard_unit i_dut (
        .clk(clk), .reset(reset), .if_busy(if_busy), .mem_busy(mem_busy),
        .br_taken(br_taken), .id_valid(id_valid), .op(op), .ra_addr(ra_addr),
        .rb_addr(rb_addr), .src_reg_used(src_reg_used), .dst_addr(dst_addr),
        .gpr_we(gpr_we), .mem_op(mem_op), .if_stall(if_stall), .id_stall(id_stall),
        .ex_stall(ex_stall), .mem_stall(mem_stall), .id_flush(id_flush),
        .ra_fwd_ctrl(ra_fwd_ctrl), .rb_fwd_ctrl(rb_fwd_ctrl),
        .ex_ra_fwd_en(ex_ra_fwd_en), .ex_rb_fwd_en(ex_rb_fwd_en)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]}; // One step per bit
        end
    endtask

    // EX has priority over MEM and r0 is never bypassed
    function automatic cpu_pkg::fwd_ctrl_e bypass_src(input logic used,
                                                      input cpu_pkg::reg_addr_t src);
        if (used && src != '0 && mdl_ex_valid && mdl_ex_we && src == mdl_ex_dst)
            return cpu_pkg::FWD_EX;
        if (used && src != '0 && mdl_mem_valid && mdl_mem_we && src == mdl_mem_dst)
            return cpu_pkg::FWD_MEM;
        return cpu_pkg::FWD_NONE;
    endfunction

    function automatic exp_t expected_outputs();
        exp_t e;
        logic ex_ld, ra_hit, rb_hit, ex_st, mem_ld;
        ex_ld  = mdl_ex_valid && mdl_ex_we && mdl_ex_mop[`MEM_OP_W-1] && mdl_ex_dst != '0;
        ra_hit = src_reg_used[0] && ra_addr == mdl_ex_dst;
        rb_hit = src_reg_used[1] && rb_addr == mdl_ex_dst && op != cpu_pkg::OP_ST;
        e.ld_hz    = id_valid && ex_ld && (ra_hit || rb_hit);
        e.stall    = if_busy | mem_busy;
        e.if_stall = e.stall | e.ld_hz;
        e.id_flush = e.ld_hz | br_taken;
        e.advance  = ~e.stall;
        e.bubble   = e.id_flush | ~id_valid;
        e.ra = e.ld_hz ? cpu_pkg::FWD_NONE : bypass_src(src_reg_used[0], ra_addr);
        e.rb = e.ld_hz ? cpu_pkg::FWD_NONE : bypass_src(src_reg_used[1], rb_addr);
        ex_st  = mdl_ex_mop[`MEM_OP_W-1 -: 2] == 2'b01;
        mem_ld = mdl_mem_valid && mdl_mem_we && mdl_mem_mop[`MEM_OP_W-1];
        e.st_a = mem_ld && ex_st && mdl_ex_ra != '0 && mdl_ex_ra == mdl_mem_dst;
        e.st_b = mem_ld && ex_st && mdl_ex_rb != '0 && mdl_ex_rb == mdl_mem_dst;
        return e;
    endfunction

    task automatic check_fwd(input string sig, input cpu_pkg::fwd_ctrl_e exp,
                             input cpu_pkg::fwd_ctrl_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED test %s: %s expected %s actual %s at %0t",
                     cur_test, sig, exp.name(), act.name(), $time);
        end
    endtask

    task automatic check_ctrl(input string sig, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED test %s: %s expected %0b actual %0b at %0t",
                     cur_test, sig, exp, act, $time);
        end
    endtask

    // Outputs settle mid-cycle and the model then takes the coming edge
    always @(negedge clk) begin : compare_outputs
        exp_t e;
        e = expected_outputs();
        if (!reset) begin
            check_ctrl("if_stall", e.if_stall, if_stall);
            check_ctrl("id_stall", e.stall, id_stall);
            check_ctrl("ex_stall", e.stall, ex_stall);
            check_ctrl("mem_stall", e.stall, mem_stall);
            check_ctrl("id_flush", e.id_flush, id_flush);
            check_fwd("ra_fwd_ctrl", e.ra, ra_fwd_ctrl);
            check_fwd("rb_fwd_ctrl", e.rb, rb_fwd_ctrl);
            check_ctrl("ex_ra_fwd_en", e.st_a, ex_ra_fwd_en);
            check_ctrl("ex_rb_fwd_en", e.st_b, ex_rb_fwd_en);
        end
        exp_if_stall = e.if_stall;
        if (e.advance) begin
            mdl_mem_we  = mdl_ex_we; // MEM takes EX before EX reloads
            mdl_mem_dst = mdl_ex_dst;
            mdl_mem_mop = mdl_ex_mop;
            mdl_ex_we   = gpr_we;
            mdl_ex_dst  = dst_addr;
            mdl_ex_ra   = ra_addr;
            mdl_ex_rb   = rb_addr;
            mdl_ex_mop  = mem_op;
        end
        if (reset) begin
            mdl_ex_valid  = 1'b0;
            mdl_mem_valid = 1'b0;
        end else if (e.advance) begin
            mdl_mem_valid = mdl_ex_valid;
            mdl_ex_valid  = id_valid & ~e.bubble;
        end
    end

    // New ID record on the edge unless fetch is expected to hold it
    task automatic present(input logic v, input cpu_pkg::opcode_t o,
                           input cpu_pkg::reg_addr_t ra, input cpu_pkg::reg_addr_t rb,
                           input logic [1:0] used, input cpu_pkg::reg_addr_t dst,
                           input logic we, input cpu_pkg::mem_op_t mop,
                           input logic ib, input logic mb, input logic br);
        @(posedge clk);
        if (!exp_if_stall) begin
            id_valid     <= v;
            op           <= o;
            ra_addr      <= ra;
            rb_addr      <= rb;
            src_reg_used <= used;
            dst_addr     <= dst;
            gpr_we       <= we;
            mem_op       <= mop;
        end
        if_busy  <= ib;
        mem_busy <= mb;
        br_taken <= br;
    endtask

    task automatic alu_op(input cpu_pkg::reg_addr_t dst, input cpu_pkg::reg_addr_t ra,
                          input cpu_pkg::reg_addr_t rb);
        present(1'b1, OP_ALU, ra, rb, 2'b11, dst, 1'b1, MOP_NONE, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic load_op(input cpu_pkg::reg_addr_t dst, input cpu_pkg::reg_addr_t base);
        present(1'b1, OP_LD, base, 5'd0, 2'b01, dst, 1'b1, MOP_LW, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic store_op(input cpu_pkg::reg_addr_t base, input cpu_pkg::reg_addr_t data);
        present(1'b1, cpu_pkg::OP_ST, base, data, 2'b11, 5'd0, 1'b0, MOP_SW,
                1'b0, 1'b0, 1'b0);
    endtask

    task automatic idle(input int n);
        repeat (n) present(1'b0, OP_ALU, 5'd0, 5'd0, 2'b00, 5'd0, 1'b0, MOP_NONE,
                           1'b0, 1'b0, 1'b0);
    endtask

    task automatic random_slot();
        logic [31:0] r;
        logic v, we, ib, mb, br;
        logic [1:0] used;
        cpu_pkg::reg_addr_t ra, rb, dst;
        cpu_pkg::mem_op_t mop;
        cpu_pkg::opcode_t o;
        rand_bits(3, r);
        v = r[2:0] != 3'b000;
        rand_bits(3, r);
        ra = {2'b00, r[2:0]}; // Small register range for frequent hazards
        rand_bits(3, r);
        rb = {2'b00, r[2:0]};
        rand_bits(3, r);
        dst = {2'b00, r[2:0]};
        rand_bits(2, r);
        used = r[1:0];
        rand_bits(1, r);
        we = r[0];
        rand_bits(`MEM_OP_W, r);
        mop = r[`MEM_OP_W-1:0];
        rand_bits(`OP_W, r);
        o = (mop[`MEM_OP_W-1 -: 2] == 2'b01 && r[0]) ? cpu_pkg::OP_ST : r[`OP_W-1:0];
        rand_bits(3, r);
        ib = r[2:0] == 3'b000;
        rand_bits(3, r);
        mb = r[2:0] == 3'b000;
        rand_bits(3, r);
        br = r[2:0] == 3'b000;
        present(v, o, ra, rb, used, dst, we, mop, ib, mb, br);
    endtask

    task automatic end_test();
        tests_done++;
        $display("test %s finished, %0d errors", cur_test, errors - test_start_errors);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_start_errors = errors;
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYC * PERIOD_NS);
        $display("Timeout: the tests did not complete within %0d cycles", WATCHDOG_CYC);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        reset = 1'b1;
        if_busy = 1'b0;
        mem_busy = 1'b0;
        br_taken = 1'b0;
        id_valid = 1'b0;
        op = OP_ALU;
        ra_addr = '0;
        rb_addr = '0;
        src_reg_used = 2'b00;
        dst_addr = '0;
        gpr_we = 1'b0;
        mem_op = MOP_NONE;
        repeat (RESET_CYC) @(posedge clk);
        reset <= 1'b0;

        start_test("after_reset");
        for (int i = 0; i < 3; i++) begin
            // Never issued, yet aimed at r5 so leaked valid bits would show
            present(1'b0, OP_ALU, 5'd5, 5'd5, 2'b11, 5'd5, 1'b1,
                    (i == 1) ? MOP_SW : MOP_LW, 1'b0, 1'b0, 1'b0);
            @(negedge clk);
            check_fwd("ra idle", cpu_pkg::FWD_NONE, ra_fwd_ctrl);
            check_fwd("rb idle", cpu_pkg::FWD_NONE, rb_fwd_ctrl);
            check_ctrl("ra store en idle", 1'b0, ex_ra_fwd_en);
            check_ctrl("rb store en idle", 1'b0, ex_rb_fwd_en);
        end
        end_test();

        start_test("alu_bypass");
        alu_op(5'd5, 5'd1, 5'd2);
        alu_op(5'd6, 5'd5, 5'd3);
        @(negedge clk);
        check_fwd("ra from EX", cpu_pkg::FWD_EX, ra_fwd_ctrl);
        alu_op(5'd5, 5'd1, 5'd2);
        alu_op(5'd7, 5'd1, 5'd2); // Independent filler
        alu_op(5'd8, 5'd5, 5'd3);
        @(negedge clk);
        check_fwd("ra from MEM", cpu_pkg::FWD_MEM, ra_fwd_ctrl);
        alu_op(5'd5, 5'd1, 5'd2);
        alu_op(5'd5, 5'd3, 5'd4);
        alu_op(5'd9, 5'd5, 5'd5);
        @(negedge clk);
        check_fwd("ra EX wins", cpu_pkg::FWD_EX, ra_fwd_ctrl);
        check_fwd("rb EX wins", cpu_pkg::FWD_EX, rb_fwd_ctrl);
        alu_op(5'd0, 5'd1, 5'd2);
        alu_op(5'd8, 5'd0, 5'd0);
        @(negedge clk);
        check_fwd("ra reads r0", cpu_pkg::FWD_NONE, ra_fwd_ctrl);
        idle(2);
        end_test();

        start_test("load_use");
        load_op(5'd7, 5'd1);
        alu_op(5'd8, 5'd7, 5'd2);
        @(negedge clk);
        check_ctrl("if_stall on load use", 1'b1, if_stall);
        check_ctrl("id_flush on load use", 1'b1, id_flush);
        check_fwd("ra while held", cpu_pkg::FWD_NONE, ra_fwd_ctrl);
        alu_op(5'd10, 5'd1, 5'd2); // Dropped while ID is held
        @(negedge clk);
        check_ctrl("if_stall released", 1'b0, if_stall);
        check_fwd("ra after hold", cpu_pkg::FWD_MEM, ra_fwd_ctrl);
        load_op(5'd7, 5'd1);
        store_op(5'd3, 5'd7);
        @(negedge clk);
        check_ctrl("no stall for store data", 1'b0, if_stall);
        idle(2);
        end_test();

        start_test("store_data");
        load_op(5'd9, 5'd1);
        store_op(5'd2, 5'd9);
        idle(1);
        @(negedge clk);
        check_ctrl("rb store en", 1'b1, ex_rb_fwd_en);
        load_op(5'd9, 5'd1);
        present(1'b1, cpu_pkg::OP_ST, 5'd9, 5'd4, 2'b10, 5'd0, 1'b0, MOP_SW,
                1'b0, 1'b0, 1'b0);
        idle(1);
        @(negedge clk);
        check_ctrl("ra store en", 1'b1, ex_ra_fwd_en);
        idle(2);
        end_test();

        start_test("busy_branch");
        alu_op(5'd5, 5'd1, 5'd2);
        repeat (3) begin
            present(1'b1, OP_ALU, 5'd5, 5'd3, 2'b11, 5'd11, 1'b1, MOP_NONE,
                    1'b0, 1'b1, 1'b0);
            @(negedge clk);
            check_ctrl("mem_stall while busy", 1'b1, mem_stall);
            check_fwd("ra frozen", cpu_pkg::FWD_EX, ra_fwd_ctrl);
        end
        idle(1);
        @(negedge clk);
        check_fwd("ra after busy", cpu_pkg::FWD_EX, ra_fwd_ctrl);
        present(1'b1, OP_ALU, 5'd1, 5'd2, 2'b11, 5'd6, 1'b1, MOP_NONE, 1'b0, 1'b0, 1'b1);
        @(negedge clk);
        check_ctrl("id_flush on branch", 1'b1, id_flush);
        alu_op(5'd12, 5'd6, 5'd6);
        @(negedge clk);
        check_fwd("flushed not in EX", cpu_pkg::FWD_NONE, ra_fwd_ctrl);
        alu_op(5'd13, 5'd6, 5'd0);
        @(negedge clk);
        check_fwd("flushed not in MEM", cpu_pkg::FWD_NONE, ra_fwd_ctrl);
        idle(2);
        end_test();

        start_test("random_stream");
        repeat (300) random_slot();
        idle(2);
        end_test();

        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_done, checks, errors, i_dut.i_assert.fail_count);
        if (errors == 0 && i_dut.i_assert.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/cpu_pkg.sv
logic/pipe_track.sv
logic/fwd_select.sv
logic/load_hazard.sv
logic/stall_ctrl.sv
logic/hazard_unit.sv
tb/hazard_unit_assertions.sv
tb/tb_hazard_unit.sv

//--- run.sh
#!/bin/sh
# Build the hazard_unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_hazard_unit \
    -Mdir obj_dir -o sim_hazard_unit
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_hazard_unit +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'RESULT: PASS'; then
    exit 0
fi
exit 1
